// File: verilog/game_pkg.sv
// shared enums and constants for the penalty game, referenced by scoped names
`default_nettype none

package game_pkg;

    // phase of the match, driven by game_flow
    typedef enum logic [1:0] {
        IDLE    = 2'b00,    // waiting for start
        SHOOTER = 2'b01,    // player kicks
        KEEPER  = 2'b10,    // player dives
        OVER    = 2'b11     // match decided, scores frozen
    } g_state;

    // play mode
    typedef enum logic {
        SOLO  = 1'b0,   // against the lfsr opponent
        MULTI = 1'b1    // board to board, scores held at zero
    } g_mode;

    // shot or dive direction
    typedef enum logic [1:0] {
        LEFT   = 2'b00,
        CENTER = 2'b01,
        RIGHT  = 2'b10,
        WIDE   = 2'b11  // off target, or a dive that covers nothing
    } kick_dir;

    // score counter width
    localparam int SCORE_W = 3;

    // first side to reach this wins
    localparam logic [SCORE_W-1:0] WIN_SCORE = 3'd5;

    // fixed tag in the low bits of the link word
    localparam logic [2:0] LINK_TAG = 3'b111;

    // opponent generator start value, must not be zero
    localparam logic [7:0] LFSR_SEED = 8'hA5;

endpackage

`default_nettype wire

// File: verilog/game_flow.sv
// match phase FSM, starts a solo match and alternates shooter and keeper roles
`default_nettype none

module game_flow (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::g_mode  game_mode,
    input  logic             start,
    input  logic             round_done_sh,
    input  logic             round_done_gk,
    input  logic             match_end,
    output game_pkg::g_state game_state
);

    game_pkg::g_state state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::IDLE;
        end else begin
            game_state <= state_nxt;
        end
    end

    // next phase
    always_comb begin
        state_nxt = game_state;    // hold by default

        case (game_state)
            game_pkg::IDLE: begin
                // multi mode has no local opponent, so start does nothing there
                if (start && (game_mode == game_pkg::SOLO)) begin
                    state_nxt = game_pkg::SHOOTER;
                end
            end

            game_pkg::SHOOTER: begin
                if (match_end) begin
                    state_nxt = game_pkg::OVER;    // end wins over a role change
                end else if (round_done_sh) begin
                    state_nxt = game_pkg::KEEPER;
                end
            end

            game_pkg::KEEPER: begin
                if (match_end) begin
                    state_nxt = game_pkg::OVER;
                end else if (round_done_gk) begin
                    state_nxt = game_pkg::SHOOTER;
                end
            end

            game_pkg::OVER: begin
                if (start) begin
                    state_nxt = game_pkg::IDLE;    // back to idle, scores clear there
                end
            end

            default: begin
                state_nxt = game_pkg::IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/penalty_round.sv
// opponent direction generator and kick judge, emits round pulses and goal flags
`default_nettype none

module penalty_round (
    input  logic              clk,
    input  logic              rst,
    input  game_pkg::g_state  game_state,
    input  logic              kick,
    input  game_pkg::kick_dir player_dir,
    output game_pkg::kick_dir enemy_dir,
    output logic              round_done_sh,
    output logic              is_scored_sh,
    output logic              round_done_gk,
    output logic              is_scored_gk,
    output logic              is_scored
);

    logic [7:0] lfsr;
    logic       lfsr_fb;
    logic [1:0] lock_cnt;      // cycles left while a result is pending
    logic       in_play;
    logic       accept;
    logic       goal_sh;
    logic       goal_gk;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // value mod 3 never yields WIDE
    assign enemy_dir = game_pkg::kick_dir'(lfsr % 8'd3);

    assign in_play = (game_state == game_pkg::SHOOTER) || (game_state == game_pkg::KEEPER);
    assign accept  = kick && in_play && (lock_cnt == 2'd0);

    // shot scores if on target and away from the keeper
    assign goal_sh = (player_dir != game_pkg::WIDE) && (player_dir != enemy_dir);
    // opponent scores unless the dive matches
    assign goal_gk = (player_dir != enemy_dir);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr          <= game_pkg::LFSR_SEED;
            lock_cnt      <= 2'd0;
            round_done_sh <= 1'b0;
            is_scored_sh  <= 1'b0;
            round_done_gk <= 1'b0;
            is_scored_gk  <= 1'b0;
            is_scored     <= 1'b0;
        end else begin
            // one-cycle pulses by default
            round_done_sh <= 1'b0;
            is_scored_sh  <= 1'b0;
            round_done_gk <= 1'b0;
            is_scored_gk  <= 1'b0;

            if (accept) begin
                lfsr     <= {lfsr[6:0], lfsr_fb};  // new opponent choice
                lock_cnt <= 2'd2;
                if (game_state == game_pkg::SHOOTER) begin
                    round_done_sh <= 1'b1;
                    is_scored_sh  <= goal_sh;
                    is_scored     <= goal_sh;
                end else begin
                    round_done_gk <= 1'b1;
                    is_scored_gk  <= goal_gk;
                    is_scored     <= goal_gk;
                end
            end else if (lock_cnt != 2'd0) begin
                lock_cnt <= lock_cnt - 2'd1;
            end

            if (game_state == game_pkg::IDLE) begin
                is_scored <= 1'b0;    // fresh match starts with no goal shown
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/score_control.sv
// goal counters, match end and result, and the eight-bit score word for the link
`default_nettype none

module score_control (
    input  logic                          clk,
    input  logic                          rst,
    input  game_pkg::g_state              game_state,
    input  logic                          is_scored_gk,
    input  logic                          is_scored_sh,
    input  logic                          round_done_gk,
    input  logic                          round_done_sh,
    input  logic                          is_scored,
    input  game_pkg::g_mode               game_mode,
    input  logic                          player_output,   // link identity bit
    output logic                          match_end,       // a side reached the win score
    output logic                          match_result,    // 1 = player won
    output logic [game_pkg::SCORE_W-1:0]  score_player,
    output logic [game_pkg::SCORE_W-1:0]  score_enemy,
    output logic [7:0]                    data_to_transmit
);

    logic [game_pkg::SCORE_W-1:0] score_player_nxt;
    logic [game_pkg::SCORE_W-1:0] score_enemy_nxt;
    logic                         match_end_nxt;
    logic                         match_result_nxt;
    logic [7:0]                   data_to_transmit_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            score_player <= '0;
            score_enemy  <= '0;
            match_end    <= 1'b0;
            match_result <= 1'b0;
        end else begin
            score_player <= score_player_nxt;
            score_enemy  <= score_enemy_nxt;
            match_end    <= match_end_nxt;
            match_result <= match_result_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_to_transmit <= 8'h00;
        end else begin
            data_to_transmit <= data_to_transmit_nxt;
        end
    end

    // identity, last goal, own score, tag
    assign data_to_transmit_nxt = {player_output, is_scored, score_player, game_pkg::LINK_TAG};

    // goal counting
    always_comb begin
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;

        if (game_mode == game_pkg::MULTI) begin
            score_player_nxt = '0;    // remote board keeps the count
            score_enemy_nxt  = '0;
        end else begin
            case (game_state)
                game_pkg::IDLE: begin
                    score_player_nxt = '0;
                    score_enemy_nxt  = '0;
                end

                game_pkg::SHOOTER: begin
                    if (round_done_sh && is_scored_sh) begin
                        score_player_nxt = score_player + 1'b1;
                    end
                end

                game_pkg::KEEPER: begin
                    if (round_done_gk && is_scored_gk) begin
                        score_enemy_nxt = score_enemy + 1'b1;
                    end
                end

                default: begin
                    // over, scores stay frozen for display
                end
            endcase
        end
    end

    // match decision from the registered scores, lands one cycle after the count
    always_comb begin
        match_end_nxt    = 1'b0;
        match_result_nxt = 1'b0;

        if (game_mode == game_pkg::SOLO) begin
            if (score_player == game_pkg::WIN_SCORE) begin
                match_end_nxt    = 1'b1;
                match_result_nxt = 1'b1;
            end else if (score_enemy == game_pkg::WIN_SCORE) begin
                match_end_nxt    = 1'b1;
                match_result_nxt = 1'b0;    // lost
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/penalty_top.sv
// top of the penalty game core, ties the flow, round judge and score blocks together
`default_nettype none

module penalty_top (
    input  logic                          clk,
    input  logic                          rst,
    input  game_pkg::g_mode               game_mode,
    input  logic                          start,
    input  logic                          kick,
    input  game_pkg::kick_dir             player_dir,      // valid with kick
    input  logic                          player_output,
    output game_pkg::g_state              game_state,
    output game_pkg::kick_dir             enemy_dir,
    output logic [game_pkg::SCORE_W-1:0]  score_player,
    output logic [game_pkg::SCORE_W-1:0]  score_enemy,
    output logic                          match_end,
    output logic                          match_result,
    output logic [7:0]                    data_to_transmit
);

    // round results into flow and score
    logic round_done_sh;
    logic is_scored_sh;
    logic round_done_gk;
    logic is_scored_gk;
    logic is_scored;

    game_flow u_game_flow (
        .clk           (clk),
        .rst           (rst),
        .game_mode     (game_mode),
        .start         (start),
        .round_done_sh (round_done_sh),
        .round_done_gk (round_done_gk),
        .match_end     (match_end),
        .game_state    (game_state)
    );

    penalty_round u_penalty_round (
        .clk           (clk),
        .rst           (rst),
        .game_state    (game_state),
        .kick          (kick),
        .player_dir    (player_dir),
        .enemy_dir     (enemy_dir),
        .round_done_sh (round_done_sh),
        .is_scored_sh  (is_scored_sh),
        .round_done_gk (round_done_gk),
        .is_scored_gk  (is_scored_gk),
        .is_scored     (is_scored)
    );

    score_control u_score_control (
        .clk              (clk),
        .rst              (rst),
        .game_state       (game_state),
        .is_scored_gk     (is_scored_gk),
        .is_scored_sh     (is_scored_sh),
        .round_done_gk    (round_done_gk),
        .round_done_sh    (round_done_sh),
        .is_scored        (is_scored),
        .game_mode        (game_mode),
        .player_output    (player_output),
        .match_end        (match_end),
        .match_result     (match_result),
        .score_player     (score_player),
        .score_enemy      (score_enemy),
        .data_to_transmit (data_to_transmit)
    );

endmodule

`default_nettype wire

// File: tests/penalty_asserts.sv
// concurrent checks on the score controller, attached to every score_control by bind
`default_nettype none

module penalty_asserts (
    input logic                         clk,
    input logic                         rst,
    input game_pkg::g_mode              game_mode,
    input logic [game_pkg::SCORE_W-1:0] score_player,
    input logic [game_pkg::SCORE_W-1:0] score_enemy,
    input logic                         match_end,
    input logic                         match_result
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // failed checks so far

    // a count past the win score means the match failed to stop
    scores_capped: assert property (@(posedge clk) disable iff (rst)
        (score_player <= game_pkg::WIN_SCORE) && (score_enemy <= game_pkg::WIN_SCORE))
        else begin
            fail_count++;
            $error("a score went above the win score");
        end

    // a result only makes sense once the match has ended
    result_needs_end: assert property (@(posedge clk) disable iff (rst)
        match_result |-> match_end)
        else begin
            fail_count++;
            $error("match_result is high while match_end is low");
        end

    multi_scores_zero: assert property (@(posedge clk) disable iff (rst)
        (game_mode == game_pkg::MULTI) |=> ((score_player == '0) && (score_enemy == '0)))
        else begin
            fail_count++;
            $error("a score moved while in multiplayer mode");
        end

endmodule

bind score_control penalty_asserts u_penalty_asserts (
    .clk          (clk),
    .rst          (rst),
    .game_mode    (game_mode),
    .score_player (score_player),
    .score_enemy  (score_enemy),
    .match_end    (match_end),
    .match_result (match_result)
);

`default_nettype wire

// File: tests/penalty_tb.sv
// testbench for penalty_top, plays directed and random rounds against a reference model
`default_nettype none

module penalty_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {SIG_STATE, SIG_EDIR, SIG_SP, SIG_SE, SIG_END, SIG_RES, SIG_WORD} sig_t;
    typedef enum {PICK_RAND, PICK_SAME, PICK_OTHER, PICK_WIDE} pick_t;

    typedef struct packed {
        logic       goal;
        logic [2:0] sp;
        logic [2:0] se;
        logic       done;   // match ends
        logic       won;
        logic [7:0] word;
    } round_t;

    logic              clk;
    logic              rst;
    game_pkg::g_mode   game_mode;
    logic              start;
    logic              kick;
    game_pkg::kick_dir player_dir;
    logic              player_output;
    game_pkg::g_state  game_state;
    game_pkg::kick_dir enemy_dir;
    logic [2:0]        score_player;
    logic [2:0]        score_enemy;
    logic              match_end;
    logic              match_result;
    logic [7:0]        data_to_transmit;

    // reference model of what the outputs should show
    game_pkg::g_state m_state;
    game_pkg::g_mode  mode_now;
    logic [2:0]       m_sp;
    logic [2:0]       m_se;
    logic             m_end;
    logic             m_res;
    logic             m_flag;   // last goal flag
    logic             link_id;

    string       q_name[$];   // pending expectations, drained at the falling edge
    sig_t        q_sig[$];
    logic [7:0]  q_exp[$];
    logic [31:0] rng;
    int          cyc;
    int          cycle_limit = 40 * 6 + 200;   // kicks times cycles per kick, plus margin

    penalty_top dut (
        .clk              (clk),
        .rst              (rst),
        .game_mode        (game_mode),
        .start            (start),
        .kick             (kick),
        .player_dir       (player_dir),
        .player_output    (player_output),
        .game_state       (game_state),
        .enemy_dir        (enemy_dir),
        .score_player     (score_player),
        .score_enemy      (score_enemy),
        .match_end        (match_end),
        .match_result     (match_result),
        .data_to_transmit (data_to_transmit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // round and score rules applied to one accepted kick
    function automatic round_t predict_round(input logic shooter, input game_pkg::g_mode mode,
                                             input game_pkg::kick_dir pdir,
                                             input game_pkg::kick_dir edir,
                                             input logic [2:0] sp, input logic [2:0] se,
                                             input logic id);
        round_t r;
        if (shooter) begin
            r.goal = (pdir != game_pkg::WIDE) && (pdir != edir);
        end else begin
            r.goal = (pdir != edir);   // a wide dive never saves
        end
        r.sp = sp;
        r.se = se;
        if (mode == game_pkg::MULTI) begin
            r.sp = 3'd0;
            r.se = 3'd0;
        end else if (r.goal && shooter) begin
            r.sp = sp + 3'd1;
        end else if (r.goal) begin
            r.se = se + 3'd1;
        end
        r.won  = (mode == game_pkg::SOLO) && (r.sp == game_pkg::WIN_SCORE);
        r.done = r.won || ((mode == game_pkg::SOLO) && (r.se == game_pkg::WIN_SCORE));
        r.word = {id, r.goal, r.sp, game_pkg::LINK_TAG};
        return r;
    endfunction

    function automatic string sig_label(input sig_t sig);
        case (sig)
            SIG_STATE: return "game_state";
            SIG_EDIR:  return "enemy_dir";
            SIG_SP:    return "score_player";
            SIG_SE:    return "score_enemy";
            SIG_END:   return "match_end";
            SIG_RES:   return "match_result";
            default:   return "data_to_transmit";
        endcase
    endfunction

    function automatic logic [7:0] observed(input sig_t sig);
        case (sig)
            SIG_STATE: return {6'b0, game_state};
            SIG_EDIR:  return {6'b0, enemy_dir};
            SIG_SP:    return {5'b0, score_player};
            SIG_SE:    return {5'b0, score_enemy};
            SIG_END:   return {7'b0, match_end};
            SIG_RES:   return {7'b0, match_result};
            default:   return data_to_transmit;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        string      label;
        sig_t       sig;
        logic [7:0] want;
        while (q_name.size() > 0) begin
            label = q_name.pop_front();
            sig   = q_sig.pop_front();
            want  = q_exp.pop_front();
            check_value({label, " ", sig_label(sig)}, want, observed(sig));
        end
        if (dut.u_score_control.u_penalty_asserts.fail_count != 0) begin
            $display("a concurrent assertion on the score controller failed");
            $display("** FAIL **");
            $fatal(1, "stopped at the first assertion failure");
        end
    end

    // value due after the current rising edge
    task automatic expect_val(input string name, input sig_t sig, input logic [7:0] value);
        q_name.push_back(name);
        q_sig.push_back(sig);
        q_exp.push_back(value);
    endtask

    task automatic expect_model(input string name);
        expect_val(name, SIG_STATE, {6'b0, m_state});
        expect_val(name, SIG_SP, {5'b0, m_sp});
        expect_val(name, SIG_SE, {5'b0, m_se});
        expect_val(name, SIG_END, {7'b0, m_end});
        expect_val(name, SIG_RES, {7'b0, m_res});
    endtask

    task automatic expect_word(input string name);
        expect_val(name, SIG_WORD, {link_id, m_flag, m_sp, game_pkg::LINK_TAG});
    endtask

    // one accepted kick, traced edge by edge from E0 to E5
    task automatic play_kick(input pick_t pick, input logic extra, input string name);
        game_pkg::kick_dir edir;
        game_pkg::kick_dir pdir;
        logic              shooter;
        round_t            r;
        @(negedge clk);
        edir = enemy_dir;
        check_value({name, " enemy_dir on target"}, 8'd1, {7'b0, edir != game_pkg::WIDE});
        if (pick == PICK_RAND) begin
            rng  = lcg_next(rng);
            pdir = game_pkg::kick_dir'(rng[31:30]);
        end else if (pick == PICK_SAME) begin
            pdir = edir;
        end else if (pick == PICK_OTHER) begin
            pdir = (edir == game_pkg::LEFT) ? game_pkg::RIGHT : game_pkg::LEFT;
        end else begin
            pdir = game_pkg::WIDE;
        end
        shooter = (m_state == game_pkg::SHOOTER);
        r = predict_round(shooter, mode_now, pdir, edir, m_sp, m_se, link_id);
        @(posedge clk);
        kick       <= 1'b1;
        player_dir <= pdir;
        @(posedge clk);    // judged here
        kick   <= 1'b0;
        m_flag = r.goal;
        @(posedge clk);
        if (extra) begin
            kick <= 1'b1;   // lands while the result is pending
        end
        expect_word(name);
        m_sp    = r.sp;
        m_se    = r.se;
        m_state = shooter ? game_pkg::KEEPER : game_pkg::SHOOTER;
        expect_model(name);
        @(posedge clk);
        kick  <= 1'b0;
        m_end = r.done;
        m_res = r.won;
        expect_model(name);
        expect_val(name, SIG_WORD, r.word);
        @(posedge clk);
        if (m_end) begin
            m_state = game_pkg::OVER;
        end
        expect_model(name);
        @(posedge clk);
        expect_model(name);
    endtask

    // kick while no round can be judged
    task automatic dropped_kick(input string name);
        @(posedge clk);
        kick       <= 1'b1;
        player_dir <= game_pkg::CENTER;
        @(posedge clk);
        kick <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            expect_model(name);
            expect_word(name);
        end
    endtask

    task automatic press_start(input string name);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (m_state == game_pkg::OVER) begin
            m_state = game_pkg::IDLE;
        end else if (m_state == game_pkg::IDLE && mode_now == game_pkg::SOLO) begin
            m_state = game_pkg::SHOOTER;
        end
        expect_model(name);
        @(posedge clk);
        if (m_state == game_pkg::IDLE) begin
            m_sp   = 3'd0;   // idle wipes the scoreboard
            m_se   = 3'd0;
            m_flag = 1'b0;
        end
        expect_model(name);
        @(posedge clk);
        if (m_state == game_pkg::IDLE) begin
            m_end = 1'b0;
            m_res = 1'b0;
        end
        expect_model(name);
        expect_word(name);
    endtask

    task automatic set_mode(input game_pkg::g_mode mode, input string name);
        @(posedge clk);
        game_mode <= mode;
        mode_now  = mode;
        @(posedge clk);
        if (mode == game_pkg::MULTI) begin
            m_sp  = 3'd0;
            m_se  = 3'd0;
            m_end = 1'b0;
            m_res = 1'b0;
        end
        expect_model(name);
        @(posedge clk);
        expect_word(name);
    endtask

    task automatic set_link(input logic id, input string name);
        @(posedge clk);
        player_output <= id;
        link_id = id;
        @(posedge clk);
        expect_word(name);
    endtask

    initial begin
        rst           = 1'b1;
        game_mode     = game_pkg::SOLO;
        start         = 1'b0;
        kick          = 1'b0;
        player_dir    = game_pkg::LEFT;
        player_output = 1'b0;
        m_state       = game_pkg::IDLE;
        mode_now      = game_pkg::SOLO;
        m_sp          = 3'd0;
        m_se          = 3'd0;
        m_end         = 1'b0;
        m_res         = 1'b0;
        m_flag        = 1'b0;
        link_id       = 1'b0;
        rng           = 32'h4a00022e;
        cyc           = 0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        expect_model("reset");
        expect_val("reset", SIG_WORD, 8'h00);
        expect_val("reset", SIG_EDIR, game_pkg::LFSR_SEED % 8'd3);
        press_start("start_solo");

        // directed shooter and keeper rounds
        play_kick(PICK_OTHER, 1'b0, "shoot_goal");
        play_kick(PICK_SAME, 1'b1, "dive_save");   // second kick must be dropped
        play_kick(PICK_SAME, 1'b0, "shoot_saved");
        play_kick(PICK_OTHER, 1'b0, "dive_beaten");
        play_kick(PICK_WIDE, 1'b0, "shoot_wide");
        play_kick(PICK_WIDE, 1'b0, "dive_wide");

        while (!m_end) begin
            play_kick(PICK_RAND, 1'b0, "random_match");
        end
        dropped_kick("over_hold");
        press_start("over_to_idle");

        set_link(1'b1, "link_toggle");
        set_mode(game_pkg::MULTI, "multi_idle");
        press_start("multi_start");   // ignored in multi
        dropped_kick("multi_kick");
        set_mode(game_pkg::SOLO, "solo_again");
        press_start("second_match");
        play_kick(PICK_OTHER, 1'b0, "link_goal");
        play_kick(PICK_OTHER, 1'b0, "link_concede");
        set_mode(game_pkg::MULTI, "multi_in_match");
        play_kick(PICK_OTHER, 1'b0, "multi_shoot");
        play_kick(PICK_OTHER, 1'b0, "multi_dive");

        repeat (2) @(posedge clk);
        @(negedge clk);
        if (dut.u_score_control.u_penalty_asserts.fail_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("a concurrent assertion on the score controller failed");
            $display("** FAIL **");
            $fatal(1, "assertion failures at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: penalty_top.f
verilog/game_pkg.sv
verilog/game_flow.sv
verilog/penalty_round.sv
verilog/score_control.sv
verilog/penalty_top.sv
tests/penalty_asserts.sv
tests/penalty_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= penalty_tb
FILELIST  ?= penalty_top.f
MDIR      ?= obj_dir

SIM     := $(MDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf $(MDIR)
